//--- Makefile
# Verilator build and run for the cache read subsystem

TOP ?= cacheReadTb
SOURCES_F ?= sources.f
LOG ?= sim.log
OBJ_DIR ?= obj_dir
VERILATOR ?= verilator
VERILATOR_FLAGS ?= --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --binary --top-module $(TOP) -f $(SOURCES_F) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) $(VERILATOR_FLAGS) --lint-only --top-module $(TOP) -f $(SOURCES_F)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- cacheRead/cacheReadInterface.sv
`timescale 1ns/1ps

module cacheReadInterface (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                reqValid,
    input  logic [cacheReadPkg::idBits-1:0]     reqId,
    input  logic [cacheReadPkg::lenBits-1:0]    reqLen,
    input  logic [cacheReadPkg::addrBits-1:0]   reqAddr,
    output logic                                reqReady,
    output logic                                beatValid,
    output logic [cacheReadPkg::idBits-1:0]     beatId,
    output logic [cacheReadPkg::beatWidth-1:0]  beatData,
    output logic                                beatLast,
    input  logic                                beatReady,
    input  logic                                memReady,
    input  logic [cacheReadPkg::wordWidth-1:0]  memData,
    output logic                                memCe,
    output logic                                memWe,
    output logic [cacheReadPkg::addrBits-1:0]   memAddr
);

    typedef struct packed {
        logic [cacheReadPkg::idBits-1:0]   id;
        logic [cacheReadPkg::addrBits-1:0] addr;
        logic [cacheReadPkg::lenBits-1:0]  len;
        logic [cacheReadPkg::lenBits-1:0]  progress;
        logic                              valid;
    } burstSlot;

    burstSlot curSlot;
    burstSlot queuedSlot;
    burstSlot incoming;

    logic readOk;
    logic readAccept;
    logic readLast;

    logic [cacheReadPkg::readLatency-1:0] inFlightSr;
    logic [cacheReadPkg::readLatency-1:0] lastSr;
    logic [cacheReadPkg::readLatency-1:0][cacheReadPkg::idBits-1:0] idSr;

    logic [cacheReadPkg::fifoCountBits-1:0] fifoFree;
    logic [cacheReadPkg::throttleBits-1:0] roomWords;
    logic [cacheReadPkg::throttleBits-1:0] inFlight;
    logic allowRead;

    logic [cacheReadPkg::wordIdxBits-1:0] wordIdx;
    logic [cacheReadPkg::wordsPerBeat-2:0][cacheReadPkg::wordWidth-1:0] accWords;
    logic wordArrives;
    logic beatDone;

    // every word that could still land needs a slot in the FIFO
    always_comb begin
        inFlight = '0;
        for (int i = 0; i < cacheReadPkg::readLatency; i++) begin
            inFlight = inFlight + cacheReadPkg::throttleBits'(inFlightSr[i]);
        end
        roomWords = cacheReadPkg::throttleBits'(fifoFree)
                  * cacheReadPkg::throttleBits'(cacheReadPkg::wordsPerBeat);
        allowRead = roomWords > inFlight;
    end

    assign readOk = curSlot.valid && allowRead;
    assign readAccept = readOk && memReady; // a fill cycle retries the same word
    assign readLast = (curSlot.progress == curSlot.len);

    assign memCe = !readOk;
    assign memWe = 1'b1;
    assign memAddr = {curSlot.addr[cacheReadPkg::addrBits-1:cacheReadPkg::lineWordBits],
                      curSlot.addr[cacheReadPkg::lineWordBits-1:0]
                      + curSlot.progress[cacheReadPkg::lineWordBits-1:0]};

    assign reqReady = !queuedSlot.valid || (readAccept && readLast);

    always_comb begin
        incoming.id = reqId;
        incoming.addr = reqAddr;
        incoming.len = reqLen;
        incoming.progress = '0;
        incoming.valid = reqValid && reqReady;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            curSlot <= '0;
            queuedSlot <= '0;
            inFlightSr <= '0;
        end else begin
            inFlightSr <= {inFlightSr[cacheReadPkg::readLatency-2:0], readAccept};
            if (readAccept && readLast) begin
                // the queued burst goes first, a same-cycle request takes its place
                if (queuedSlot.valid) begin
                    curSlot <= queuedSlot;
                    queuedSlot <= incoming;
                end else begin
                    curSlot <= incoming;
                end
            end else begin
                if (readAccept) begin
                    curSlot.progress <= curSlot.progress + 1'b1;
                end
                if (incoming.valid) begin
                    if (!curSlot.valid) begin
                        curSlot <= incoming;
                    end else begin
                        queuedSlot <= incoming;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        lastSr <= {lastSr[cacheReadPkg::readLatency-2:0], readLast};
        idSr <= {idSr[cacheReadPkg::readLatency-2:0], curSlot.id};
    end

    assign wordArrives = inFlightSr[cacheReadPkg::readLatency-1];
    assign beatDone = wordArrives
                    && (wordIdx == cacheReadPkg::wordIdxBits'(cacheReadPkg::wordsPerBeat - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            wordIdx <= '0;
        end else if (wordArrives) begin
            wordIdx <= wordIdx + 1'b1; // wraps back to zero after the fourth word
        end
    end

    always_ff @(posedge clk) begin
        if (wordArrives && !beatDone) begin
            accWords[wordIdx] <= memData;
        end
    end

    // the fourth word skips the register and goes straight into the top of the beat
    syncFifo #(
        .width(cacheReadPkg::beatWidth + cacheReadPkg::idBits + 1),
        .depth(cacheReadPkg::fifoDepth)
    ) outFifo_i (
        .clk(clk),
        .rst(rst),
        .inValid(beatDone),
        .inData({lastSr[cacheReadPkg::readLatency-1], idSr[cacheReadPkg::readLatency-1],
                 memData, accWords}),
        .free(fifoFree),
        .outReady(beatReady),
        .outValid(beatValid),
        .outData({beatLast, beatId, beatData})
    );

endmodule

//--- common/cacheReadPkg.sv
package cacheReadPkg;

    // data array geometry
    localparam int addrBits = 10;
    localparam int memWords = 1 << addrBits;
    localparam int wordWidth = 32;

    // a line holds 16 words, so the low four address bits wrap inside it
    localparam int lineWordBits = 4;

    // request fields
    localparam int idBits = 2;
    localparam int lenBits = 8;

    // output beats carry four SRAM words each
    localparam int beatWidth = 128;
    localparam int wordsPerBeat = beatWidth / wordWidth;
    localparam int wordIdxBits = $clog2(wordsPerBeat);

    localparam int fifoDepth = 4;
    localparam int fifoCountBits = $clog2(fifoDepth + 1);

    // wide enough for fifoDepth * wordsPerBeat words of room
    localparam int throttleBits = fifoCountBits + wordIdxBits;

    localparam int readLatency = 2;

endpackage

//--- source/cacheDataArray.sv
`timescale 1ns/1ps

module cacheDataArray (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                memCe,
    input  logic                                memWe,
    input  logic [cacheReadPkg::addrBits-1:0]   memAddr,
    input  logic                                fillValid,
    input  logic [cacheReadPkg::addrBits-1:0]   fillAddr,
    input  logic [cacheReadPkg::wordWidth-1:0]  fillData,
    output logic                                memReady,
    output logic [cacheReadPkg::wordWidth-1:0]  memData
);

    logic [cacheReadPkg::wordWidth-1:0] mem [cacheReadPkg::memWords];

    logic readAccept;
    logic [cacheReadPkg::addrBits-1:0] rdAddr;
    logic rdPending;

    // a fill owns the single port for its cycle
    assign memReady = !fillValid;

    // the read side only issues reads, so memWe stays high on a valid access
    assign readAccept = !memCe && memWe && memReady;

    always_ff @(posedge clk) begin
        if (fillValid) begin
            mem[fillAddr] <= fillData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPending <= 1'b0;
        end else begin
            rdPending <= readAccept;
        end
    end

    // first stage holds the address, second stage holds the word
    always_ff @(posedge clk) begin
        if (readAccept) begin
            rdAddr <= memAddr;
        end
        if (rdPending) begin
            memData <= mem[rdAddr]; // stays put between reads
        end
    end

endmodule

//--- source/cacheReadTop.sv
`timescale 1ns/1ps

module cacheReadTop (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                reqValid,
    input  logic [cacheReadPkg::idBits-1:0]     reqId,
    input  logic [cacheReadPkg::lenBits-1:0]    reqLen,
    input  logic [cacheReadPkg::addrBits-1:0]   reqAddr,
    output logic                                reqReady,
    output logic                                beatValid,
    output logic [cacheReadPkg::idBits-1:0]     beatId,
    output logic [cacheReadPkg::beatWidth-1:0]  beatData,
    output logic                                beatLast,
    input  logic                                beatReady,
    input  logic                                fillValid,
    input  logic [cacheReadPkg::addrBits-1:0]   fillAddr,
    input  logic [cacheReadPkg::wordWidth-1:0]  fillData
);

    // port between the read side and the SRAM
    logic memCe;
    logic memWe;
    logic [cacheReadPkg::addrBits-1:0] memAddr;
    logic memReady;
    logic [cacheReadPkg::wordWidth-1:0] memData;

    cacheReadInterface readIf_i (
        .clk(clk),
        .rst(rst),
        .reqValid(reqValid),
        .reqId(reqId),
        .reqLen(reqLen),
        .reqAddr(reqAddr),
        .reqReady(reqReady),
        .beatValid(beatValid),
        .beatId(beatId),
        .beatData(beatData),
        .beatLast(beatLast),
        .beatReady(beatReady),
        .memReady(memReady),
        .memData(memData),
        .memCe(memCe),
        .memWe(memWe),
        .memAddr(memAddr)
    );

    cacheDataArray dataArray_i (
        .clk(clk),
        .rst(rst),
        .memCe(memCe),
        .memWe(memWe),
        .memAddr(memAddr),
        .fillValid(fillValid),
        .fillAddr(fillAddr),
        .fillData(fillData),
        .memReady(memReady),
        .memData(memData)
    );

endmodule

//--- source/syncFifo.sv
`timescale 1ns/1ps

module syncFifo #(
    parameter int width = 32,
    parameter int depth = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         inValid,
    input  logic [width-1:0]             inData,
    output logic [$clog2(depth+1)-1:0]   free,
    input  logic                         outReady,
    output logic                         outValid,
    output logic [width-1:0]             outData
);

    logic [width-1:0] mem [depth];

    // a single-entry FIFO still needs a one-bit pointer
    logic [(depth > 1 ? $clog2(depth) : 1)-1:0] wrPtr;
    logic [(depth > 1 ? $clog2(depth) : 1)-1:0] rdPtr;
    logic [$clog2(depth+1)-1:0] count;
    logic doWrite;
    logic doRead;

    assign outValid = (count != '0);
    assign outData = mem[rdPtr];
    assign free = ($clog2(depth+1))'(depth) - count;

    assign doWrite = inValid && (int'(count) != depth); // dropped when full
    assign doRead = outValid && outReady;

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= inData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= (int'(wrPtr) == depth - 1) ? '0 : wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= (int'(rdPtr) == depth - 1) ? '0 : rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count; // both or neither leave the level alone
            endcase
        end
    end

endmodule

//--- sources.f
common/cacheReadPkg.sv
source/syncFifo.sv
cacheRead/cacheReadInterface.sv
source/cacheDataArray.sv
source/cacheReadTop.sv
test/cacheReadTb.sv

//--- test/cacheReadTb.sv
`timescale 1ns/1ps

module cacheReadTb;

    localparam int clkPeriod = 4;
    localparam int resetCycles = 10;
    localparam int rngSeed = 39;
    localparam int burstCount = 12;
    localparam int reqWaitLimit = 500;
    localparam int drainLimit = 4000;

    typedef struct {
        logic [cacheReadPkg::idBits-1:0] id;
        logic [cacheReadPkg::addrBits-1:0] addr;
        logic [cacheReadPkg::lenBits-1:0] len;
    } burstExp;

    logic clk;
    logic rst;
    logic reqValid;
    logic [cacheReadPkg::idBits-1:0] reqId;
    logic [cacheReadPkg::lenBits-1:0] reqLen;
    logic [cacheReadPkg::addrBits-1:0] reqAddr;
    logic reqReady;
    logic beatValid;
    logic [cacheReadPkg::idBits-1:0] beatId;
    logic [cacheReadPkg::beatWidth-1:0] beatData;
    logic beatLast;
    logic beatReady;
    logic fillValid;
    logic [cacheReadPkg::addrBits-1:0] fillAddr;
    logic [cacheReadPkg::wordWidth-1:0] fillData;

    logic [cacheReadPkg::wordWidth-1:0] shadow [cacheReadPkg::memWords];
    burstExp expQ[$];
    burstExp headExp;
    logic [cacheReadPkg::addrBits-1:0] filled[$];
    int headBeat;
    int lastBeat;
    int errors;
    int checks;
    int startErrs;
    int spin;
    bit burstsDone;

    cacheReadTop dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // line bits stay, word bits roll over inside the 16-word line
    function automatic logic [cacheReadPkg::addrBits-1:0] wordAddr(
        input logic [cacheReadPkg::addrBits-1:0] start, input int k);
        logic [cacheReadPkg::lineWordBits-1:0] w;
        w = start[cacheReadPkg::lineWordBits-1:0] + cacheReadPkg::lineWordBits'(k);
        return {start[cacheReadPkg::addrBits-1:cacheReadPkg::lineWordBits], w};
    endfunction

    function automatic logic [cacheReadPkg::beatWidth-1:0] expectBeat(
        input logic [cacheReadPkg::addrBits-1:0] start, input int beatIndex);
        logic [cacheReadPkg::beatWidth-1:0] beat;
        for (int k = 0; k < cacheReadPkg::wordsPerBeat; k++) begin
            beat[k*cacheReadPkg::wordWidth +: cacheReadPkg::wordWidth] =
                shadow[wordAddr(start, beatIndex * cacheReadPkg::wordsPerBeat + k)];
        end
        return beat;
    endfunction

    task automatic checkEq(input logic [cacheReadPkg::beatWidth-1:0] got,
                           input logic [cacheReadPkg::beatWidth-1:0] want, input string what);
        checks++;
        if (got !== want) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("timeout: gave up waiting for %s", what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic finishTest(input int num, input string name);
        $display("test %0d (%s) done with %0d errors", num, name, errors - startErrs);
        startErrs = errors;
    endtask

    task automatic fillWord(input logic [cacheReadPkg::addrBits-1:0] addr,
                            input logic [cacheReadPkg::wordWidth-1:0] data);
        @(negedge clk);
        fillValid = 1'b1;
        fillAddr = addr;
        fillData = data;
        shadow[addr] = data; // the array takes it on the next rising edge
    endtask

    // leaves reqValid high so that the next call can follow back to back
    task automatic sendReq(input logic [cacheReadPkg::idBits-1:0] id,
                           input logic [cacheReadPkg::lenBits-1:0] len,
                           input logic [cacheReadPkg::addrBits-1:0] addr);
        int waited;
        burstExp e;
        waited = 0;
        @(negedge clk);
        reqValid = 1'b1;
        reqId = id;
        reqLen = len;
        reqAddr = addr;
        @(posedge clk);
        while (!reqReady) begin
            waited++;
            if (waited > reqWaitLimit) timeoutFail("reqReady on a burst request");
            @(posedge clk);
        end
        e.id = id;
        e.addr = addr;
        e.len = len;
        expQ.push_back(e);
    endtask

    task automatic sendRandom(input int lineLo, input int lineHi);
        logic [cacheReadPkg::addrBits-1:0] addr;
        logic [cacheReadPkg::lenBits-1:0] len;
        addr = cacheReadPkg::addrBits'($urandom_range(lineLo, lineHi)
               * (1 << cacheReadPkg::lineWordBits) + $urandom_range(0, 15));
        len = cacheReadPkg::lenBits'($urandom_range(0, 3) * 4 + 3);
        sendReq(cacheReadPkg::idBits'($urandom_range(0, 3)), len, addr);
    endtask

    task automatic dropReq();
        @(negedge clk);
        reqValid = 1'b0;
    endtask

    task automatic waitDrain(input string what);
        int waited;
        waited = 0;
        while (expQ.size() != 0) begin
            if (waited > drainLimit) timeoutFail(what);
            @(posedge clk);
            waited++;
        end
    endtask

    // beats leave in request order, so the head of the queue owns every beat
    always @(posedge clk) begin
        if (!rst && beatValid && beatReady) begin
            if (expQ.size() == 0) begin
                $display("a beat came out at %0t with no request open for it", $time);
                errors++;
            end else begin
                headExp = expQ[0];
                lastBeat = (int'(headExp.len) + 1) / cacheReadPkg::wordsPerBeat - 1;
                checkEq(beatData, expectBeat(headExp.addr, headBeat), "beat data");
                checkEq(cacheReadPkg::beatWidth'(beatId),
                        cacheReadPkg::beatWidth'(headExp.id), "beat id");
                checkEq(cacheReadPkg::beatWidth'(beatLast),
                        cacheReadPkg::beatWidth'(headBeat == lastBeat), "beat last");
                if (headBeat == lastBeat) begin
                    expQ.delete(0);
                    headBeat = 0;
                end else begin
                    headBeat++;
                end
            end
        end
    end

    initial begin
        void'($urandom(rngSeed));
        rst = 1'b1;
        reqValid = 1'b0;
        reqId = '0;
        reqLen = '0;
        reqAddr = '0;
        beatReady = 1'b1;
        fillValid = 1'b0;
        fillAddr = '0;
        fillData = '0;
        errors = 0;
        checks = 0;
        startErrs = 0;
        headBeat = 0;
        burstsDone = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        checkEq(cacheReadPkg::beatWidth'(beatValid), '0, "beatValid after reset");
        checkEq(cacheReadPkg::beatWidth'(reqReady), 1, "reqReady after reset");
        for (int a = 0; a < cacheReadPkg::memWords; a++) begin
            fillWord(cacheReadPkg::addrBits'(a), $urandom);
        end
        @(negedge clk);
        fillValid = 1'b0;
        sendReq(2'd1, 8'd3, cacheReadPkg::addrBits'($urandom_range(0, 63) * 16));
        dropReq();
        waitDrain("the single beat of test 1");
        finishTest(1, "single burst");

        for (int i = 0; i < 4; i++) begin
            sendReq(cacheReadPkg::idBits'(i), 8'd15,
                    cacheReadPkg::addrBits'($urandom_range(0, 63) * 16 + $urandom_range(1, 15)));
        end
        dropReq();
        waitDrain("the wrapping bursts of test 2");
        finishTest(2, "wrapping bursts");

        for (int i = 0; i < burstCount; i++) sendRandom(0, 63);
        dropReq();
        waitDrain("the back-to-back bursts of test 3");
        finishTest(3, "back-to-back bursts");

        burstsDone = 1'b0;
        spin = 0;
        fork
            begin
                for (int i = 0; i < burstCount; i++) sendRandom(0, 63);
                dropReq();
                waitDrain("the stalled bursts of test 4");
                burstsDone = 1'b1;
            end
            while (!burstsDone && spin < 10 * drainLimit) begin
                @(negedge clk);
                beatReady = 1'($urandom_range(0, 1));
                spin++;
            end
        join
        @(negedge clk);
        beatReady = 1'b1;
        finishTest(4, "beat back-pressure");

        // bursts read the lower half while fills land in the upper half
        burstsDone = 1'b0;
        spin = 0;
        fork
            begin
                for (int i = 0; i < burstCount; i++) sendRandom(0, 31);
                dropReq();
                waitDrain("the bursts during fills in test 5");
                burstsDone = 1'b1;
            end
            while (!burstsDone && spin < 10 * drainLimit) begin
                if ($urandom_range(0, 1) == 1) begin
                    filled.push_back(cacheReadPkg::addrBits'($urandom_range(512, 1023)));
                    fillWord(filled[filled.size() - 1], $urandom);
                end else begin
                    @(negedge clk);
                    fillValid = 1'b0;
                end
                spin++;
            end
        join
        @(negedge clk);
        fillValid = 1'b0;
        for (int i = 0; i < 6 && filled.size() != 0; i++) begin
            sendReq(cacheReadPkg::idBits'(i), 8'd15, filled[$urandom_range(0, filled.size() - 1)]);
        end
        dropReq();
        waitDrain("the bursts over filled lines in test 5");
        finishTest(5, "fills during reads");

        $display("tests run: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
